//--- all.f
src/accel_pkg.sv
src/spi_byte_engine.sv
src/spi_cs_framer.sv
src/accel_id_sequencer.sv
src/seven_seg_decoder.sv
src/accel_id_reader_top.sv
verification/spi_sensor_model.sv
verification/tb_accel_id_reader.sv

//--- Makefile
# Verilator build and run of the accelerometer ID reader testbench

BIN  := obj_dir/Vtb_accel_id_reader
SRCS := $(wildcard src/*.sv verification/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): all.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_accel_id_reader -f all.f

# Fails unless the pass line shows up in the simulation output
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

//--- verification/accel_testdata.txt
// One hex byte per line, the device ID the sensor model returns in each read frame
// Lines are used in order, first read frame first
AD
1E
5F
27
90
C3
48
6B
F0
5A

//--- verification/tb_accel_id_reader.sv
// Testbench for the accelerometer ID reader, runs the DUT against the sensor model and testdata file
`timescale 1ns/1ns
`default_nettype none

module tb_accel_id_reader;

  localparam int N_READS    = 10;  // Values in the data file
  localparam int MIN_WAIT   = 8;   // Enough clocks for a frame to begin if start were ignored
  localparam int MAX_WAIT   = 32;  // Spread of the random hold of start low
  localparam int CLK_NS     = 20;
  localparam int RESET_CLKS = 5;
  localparam int FRAME_CLKS = 3 * accel_pkg::EDGES_PER_BYTE * accel_pkg::CLKS_PER_HALF_BIT;
  localparam int WATCHDOG_NS =
    ((N_READS + 1) * FRAME_CLKS * 2 + RESET_CLKS + MIN_WAIT + MAX_WAIT) * CLK_NS;
  // Guard gap, then sequencer sees ready, drives the strobe, and CS falls after it
  localparam int MIN_GAP_CLKS = accel_pkg::CS_INACTIVE_CLKS + 3;

  localparam logic [23:0] WAKE_FRAME = 24'h0A2D0A;  // Write opcode, POWER_CTL, measure
  localparam logic [23:0] READ_FRAME = 24'h0B0894;  // Read opcode, DEVID, dummy
  localparam logic [6:0]  SEG_CODE [16] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
    7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
  };

  logic                 clk;
  logic                 rst_l;
  logic                 start;
  logic                 w_miso;
  accel_pkg::spi_pins_t w_spi;
  logic                 w_cs_n;
  logic [7:0]           w_id_byte;
  logic [6:0]           w_hex0;
  logic [6:0]           w_hex1;
  logic [7:0]           r_value;       // ID the model answers in the current read
  logic [23:0]          w_frame;
  logic [7:0]           w_frame_len;
  int                   w_frame_cnt;
  logic [7:0]           id_mem [0:N_READS-1];
  logic [15:0]          nibbles_seen;
  int                   test_errs;
  int                   pass_cnt;
  int                   fail_cnt;
  int unsigned          seed;
  int unsigned          wait_clks;
  int unsigned          gap;
  string                tname;

  assign w_cs_n = w_spi.cs_n;

  accel_id_reader_top DUT
  (
    .i_Clk      (clk),
    .i_Rst_L    (rst_l),
    .i_start    (start),
    .i_spi_miso (w_miso),
    .o_spi      (w_spi),
    .o_id_byte  (w_id_byte),
    .o_hex0     (w_hex0),
    .o_hex1     (w_hex1)
  );

  spi_sensor_model u_sensor
  (
    .i_sclk      (w_spi.sclk),
    .i_mosi      (w_spi.mosi),
    .i_cs_n      (w_spi.cs_n),
    .i_value     (r_value),
    .o_miso      (w_miso),
    .o_frame     (w_frame),
    .o_frame_len (w_frame_len),
    .o_frame_cnt (w_frame_cnt)
  );

  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  //////////////////////////////
  // Check helpers
  //////////////////////////////
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp)
    else
    begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_cond(input bit ok, input string msg);
    assert (ok)
    else
    begin
      $display("%s", msg);
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0)
    begin
      pass_cnt++;
      $display("PASS %s", name);
    end
    else
    begin
      fail_cnt++;
      $display("FAIL %s with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    rst_l        = 1'b0;
    start        = 1'b0;
    r_value      = 8'h00;
    nibbles_seen = '0;
    test_errs    = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    seed         = $urandom(32'h1e70);
    $readmemh("verification/accel_testdata.txt", id_mem);
    r_value = id_mem[0];

    repeat (RESET_CLKS) @(posedge clk);
    #2;
    check_value("reset_state cs_n", 32'(1), 32'(w_spi.cs_n));
    check_value("reset_state sclk", 32'(0), 32'(w_spi.sclk));
    check_value("reset_state mosi", 32'(0), 32'(w_spi.mosi));
    check_value("reset_state id_byte", 32'(0), 32'(w_id_byte));
    check_value("reset_state hex0", 32'(SEG_CODE[0]), 32'(w_hex0));
    check_value("reset_state hex1", 32'(SEG_CODE[0]), 32'(w_hex1));
    rst_l = 1'b1;
    end_test("reset_state");

    // Bus must stay quiet for a random time with start low
    wait_clks = MIN_WAIT + ($urandom % MAX_WAIT);
    repeat (wait_clks)
    begin
      @(posedge clk);
      #2;
      check_cond(w_cs_n == 1'b1, "start_low_quiet: CS fell while start was low");
    end
    start = 1'b1;
    end_test("start_low_quiet");

    @(posedge w_cs_n);  // End of the wake frame
    #1;
    check_value("wake_frame bytes", 32'(WAKE_FRAME), 32'(w_frame));
    check_value("wake_frame length", 32'(3), 32'(w_frame_len));
    check_value("wake_frame count", 32'(1), 32'(w_frame_cnt));
    end_test("wake_frame");

    for (int r = 0; r < N_READS; r++)
    begin
      // CS high time before this frame, in whole clocks
      gap = 0;
      do
      begin
        @(posedge clk);
        #1;
        gap++;
      end while (w_cs_n);
      tname = $sformatf("cs_gap_%0d", r);
      check_cond(gap >= MIN_GAP_CLKS,
                 $sformatf("%s: CS high for only %0d clocks", tname, gap));
      end_test(tname);

      @(posedge w_cs_n);
      #1;
      tname = $sformatf("read_frame_%0d", r);
      check_value({tname, " bytes"}, 32'(READ_FRAME), 32'(w_frame));
      check_value({tname, " length"}, 32'(3), 32'(w_frame_len));
      check_value({tname, " id_byte"}, 32'(id_mem[4'(r)]), 32'(w_id_byte));
      end_test(tname);

      tname = $sformatf("display_%0d", r);
      check_value({tname, " hex0"}, 32'(SEG_CODE[id_mem[4'(r)][3:0]]), 32'(w_hex0));
      check_value({tname, " hex1"}, 32'(SEG_CODE[id_mem[4'(r)][7:4]]), 32'(w_hex1));
      end_test(tname);
      nibbles_seen[id_mem[4'(r)][3:0]] = 1'b1;
      nibbles_seen[id_mem[4'(r)][7:4]] = 1'b1;

      if (r + 1 < N_READS)
        r_value = id_mem[4'(r + 1)];  // Ready long before the next third byte
    end

    check_value("nibble_coverage", 32'hFFFF, 32'(nibbles_seen));
    end_test("nibble_coverage");

    $display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // Watchdog, twice the nominal SPI time of all frames
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the DUT stopped framing before all read frames were checked");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/spi_sensor_model.sv
// Behavioral mode 0 SPI sensor for the testbench, records MOSI frames and answers ID reads on MISO
`timescale 1ns/1ns
`default_nettype none

module spi_sensor_model
(
  input  wire         i_sclk,
  input  wire         i_mosi,
  input  wire         i_cs_n,
  input  wire  [7:0]  i_value,      // ID returned in the third byte of a read
  output logic        o_miso,
  output logic [23:0] o_frame,      // Last finished frame, first byte on top
  output logic [7:0]  o_frame_len,  // Bytes seen under that CS low
  output int          o_frame_cnt   // Finished frames so far
);

  localparam logic [7:0] READ_OPCODE = 8'h0B;

  logic [7:0] bytes_q [$];  // Bytes of the open frame
  logic [7:0] rx_shift;
  int         bit_cnt;      // Bits of the current byte already shifted in

  initial
  begin
    o_miso      = 1'b0;
    o_frame     = '0;
    o_frame_len = '0;
    o_frame_cnt = 0;
    rx_shift    = '0;
    bit_cnt     = 0;
  end

  //////////////////////////////
  // MOSI capture
  //////////////////////////////
  // A CS fall opens a new frame, SCLK low at that point
  always @(posedge i_sclk or negedge i_cs_n)
  begin
    if (!i_sclk)
    begin
      bytes_q.delete();
      bit_cnt = 0;
    end
    else if (!i_cs_n)
    begin
      rx_shift = {rx_shift[6:0], i_mosi};  // MSB first
      bit_cnt  = bit_cnt + 1;
      if (bit_cnt == 8)
      begin
        bytes_q.push_back(rx_shift);
        bit_cnt = 0;
      end
    end
  end

  // Publish the frame when CS rises, the rise out of reset carries no bytes
  always @(posedge i_cs_n)
  begin
    if (bytes_q.size() > 0)
    begin
      o_frame = '0;
      for (int i = 0; i < 3; i++)
        o_frame = {o_frame[15:0], (i < bytes_q.size()) ? bytes_q[i] : 8'h00};
      o_frame_len = 8'(bytes_q.size());
      o_frame_cnt = o_frame_cnt + 1;
    end
  end

  //////////////////////////////
  // MISO reply
  //////////////////////////////
  // Mode 0 slave changes data on the falling edge
  always @(negedge i_sclk)
  begin
    if (bytes_q.size() == 2 && bytes_q[0] == READ_OPCODE)
      o_miso = i_value[3'(7 - bit_cnt)];  // Third byte of a read
    else
      o_miso = 1'b0;
  end

endmodule

`default_nettype wire

//--- src/accel_id_reader_top.sv
// Top level of the accelerometer ID reader, SPI pins out and the ID byte on two hex digits
`timescale 1ns/1ns
`default_nettype none

module accel_id_reader_top
(
  input  wire                  i_Clk,
  input  wire                  i_Rst_L,
  input  wire                  i_start,
  input  wire                  i_spi_miso,
  output accel_pkg::spi_pins_t o_spi,
  output logic [7:0]           o_id_byte,
  output logic [6:0]           o_hex0,     // Low nibble
  output logic [6:0]           o_hex1      // High nibble
);

  accel_pkg::tx_req_t  w_tx;        // Sequencer to framer
  logic                w_tx_ready;
  accel_pkg::rx_beat_t w_rx;        // Engine receive strobe, back to the sequencer

  accel_id_sequencer u_sequencer
  (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_start    (i_start),
    .i_tx_ready (w_tx_ready),
    .i_rx       (w_rx),
    .o_tx       (w_tx),
    .o_id_byte  (o_id_byte)
  );

  spi_cs_framer u_framer
  (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx       (w_tx),
    .i_miso     (i_spi_miso),
    .o_tx_ready (w_tx_ready),
    .o_rx       (w_rx),
    .o_spi      (o_spi)
  );

  // Display digits
  seven_seg_decoder u_hex0
  (
    .i_nibble   (o_id_byte[3:0]),
    .o_segments (o_hex0)
  );

  seven_seg_decoder u_hex1
  (
    .i_nibble   (o_id_byte[7:4]),
    .o_segments (o_hex1)
  );

endmodule

`default_nettype wire

//--- src/seven_seg_decoder.sv
// Hex nibble to active-low seven-segment pattern, bit 6 is segment g and bit 0 is segment a
`timescale 1ns/1ns
`default_nettype none

module seven_seg_decoder
(
  input  wire  [3:0] i_nibble,
  output logic [6:0] o_segments  // Low lights a segment
);

  always_comb
  begin
    case (i_nibble)
      4'h0: o_segments = 7'b1000000;
      4'h1: o_segments = 7'b1111001;
      4'h2: o_segments = 7'b0100100;
      4'h3: o_segments = 7'b0110000;
      4'h4: o_segments = 7'b0011001;
      4'h5: o_segments = 7'b0010010;
      4'h6: o_segments = 7'b0000010;
      4'h7: o_segments = 7'b1111000;
      4'h8: o_segments = 7'b0000000;  // All on
      4'h9: o_segments = 7'b0010000;
      4'hA: o_segments = 7'b0001000;
      4'hB: o_segments = 7'b0000011;  // Lower case b
      4'hC: o_segments = 7'b1000110;
      4'hD: o_segments = 7'b0100001;  // Lower case d
      4'hE: o_segments = 7'b0000110;
      4'hF: o_segments = 7'b0001110;
      default: o_segments = 7'b1111111;  // Blank
    endcase
  end

endmodule

`default_nettype wire

//--- src/accel_id_sequencer.sv
// Sends the sensor wake frame once, then loops device-ID read frames and latches the ID byte
`timescale 1ns/1ns
`default_nettype none

module accel_id_sequencer
(
  input  wire                  i_Clk,
  input  wire                  i_Rst_L,
  input  wire                  i_start,     // Level, run while high at the start
  input  wire                  i_tx_ready,
  input  wire accel_pkg::rx_beat_t i_rx,
  output accel_pkg::tx_req_t   o_tx,
  output logic [7:0]           o_id_byte    // Valid from the CS rise of each read frame
);

  accel_pkg::seq_state_e r_state;

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state   <= accel_pkg::SEQ_IDLE;
      o_tx      <= '0;
      o_id_byte <= 8'h00;  // Both digits read 0
    end
    else
    begin
      o_tx.dv <= 1'b0;  // Strobe lasts one clock

      case (r_state)
        accel_pkg::SEQ_IDLE:
        begin
          if (i_start && i_tx_ready)
          begin
            r_state <= accel_pkg::SEQ_WAKE_CMD_SEND;
          end
        end

        //////////////////////////////
        // Wake frame
        //////////////////////////////
        accel_pkg::SEQ_WAKE_CMD_SEND:
        begin
          o_tx.dv    <= 1'b1;
          o_tx.data  <= accel_pkg::CMD_WRITE;
          o_tx.count <= accel_pkg::frame_cnt_t'(accel_pkg::MAX_BYTES_PER_FRAME);
          r_state    <= accel_pkg::SEQ_WAKE_CMD_DROP;
        end
        accel_pkg::SEQ_WAKE_CMD_DROP: r_state <= accel_pkg::SEQ_WAKE_CMD_WAIT;
        accel_pkg::SEQ_WAKE_CMD_WAIT:
        begin
          if (i_tx_ready)
            r_state <= accel_pkg::SEQ_WAKE_REG_SEND;
        end
        accel_pkg::SEQ_WAKE_REG_SEND:
        begin
          o_tx.dv   <= 1'b1;
          o_tx.data <= accel_pkg::REG_POWER_CTL;
          r_state   <= accel_pkg::SEQ_WAKE_REG_DROP;
        end
        accel_pkg::SEQ_WAKE_REG_DROP: r_state <= accel_pkg::SEQ_WAKE_REG_WAIT;
        accel_pkg::SEQ_WAKE_REG_WAIT:
        begin
          if (i_tx_ready)
            r_state <= accel_pkg::SEQ_WAKE_VAL_SEND;
        end
        accel_pkg::SEQ_WAKE_VAL_SEND:
        begin
          o_tx.dv   <= 1'b1;
          o_tx.data <= accel_pkg::WAKE_VALUE;
          r_state   <= accel_pkg::SEQ_WAKE_VAL_DROP;
        end
        accel_pkg::SEQ_WAKE_VAL_DROP: r_state <= accel_pkg::SEQ_WAKE_VAL_WAIT;
        accel_pkg::SEQ_WAKE_VAL_WAIT:
        begin
          if (i_tx_ready)  // Framer idle again after the gap
            r_state <= accel_pkg::SEQ_RD_CMD_SEND;
        end

        //////////////////////////////
        // Read frame, repeats forever
        //////////////////////////////
        accel_pkg::SEQ_RD_CMD_SEND:
        begin
          o_tx.dv    <= 1'b1;
          o_tx.data  <= accel_pkg::CMD_READ;
          o_tx.count <= accel_pkg::frame_cnt_t'(accel_pkg::MAX_BYTES_PER_FRAME);
          r_state    <= accel_pkg::SEQ_RD_CMD_DROP;
        end
        accel_pkg::SEQ_RD_CMD_DROP: r_state <= accel_pkg::SEQ_RD_CMD_WAIT;
        accel_pkg::SEQ_RD_CMD_WAIT:
        begin
          if (i_tx_ready)
            r_state <= accel_pkg::SEQ_RD_REG_SEND;
        end
        accel_pkg::SEQ_RD_REG_SEND:
        begin
          o_tx.dv   <= 1'b1;
          o_tx.data <= accel_pkg::REG_DEVID;
          r_state   <= accel_pkg::SEQ_RD_REG_DROP;
        end
        accel_pkg::SEQ_RD_REG_DROP: r_state <= accel_pkg::SEQ_RD_REG_WAIT;
        accel_pkg::SEQ_RD_REG_WAIT:
        begin
          if (i_tx_ready)
            r_state <= accel_pkg::SEQ_RD_DUMMY_SEND;
        end
        accel_pkg::SEQ_RD_DUMMY_SEND:
        begin
          o_tx.dv   <= 1'b1;
          o_tx.data <= accel_pkg::DUMMY_BYTE;
          r_state   <= accel_pkg::SEQ_RD_DUMMY_DROP;
        end
        accel_pkg::SEQ_RD_DUMMY_DROP: r_state <= accel_pkg::SEQ_RD_DUMMY_WAIT;
        accel_pkg::SEQ_RD_DUMMY_WAIT:
        begin
          // ID byte arrives before CS rises, ready follows the gap
          if (i_rx.dv)
            o_id_byte <= i_rx.data;
          if (i_tx_ready)
            r_state <= accel_pkg::SEQ_RD_CMD_SEND;
        end
        default: r_state <= accel_pkg::SEQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/spi_cs_framer.sv
// Holds chip select low over a counted frame of bytes and keeps it high for the guard gap after
`timescale 1ns/1ns
`default_nettype none

module spi_cs_framer
(
  input  wire                  i_Clk,
  input  wire                  i_Rst_L,
  input  wire accel_pkg::tx_req_t i_tx,
  input  wire                  i_miso,
  output logic                 o_tx_ready,  // Upstream may strobe while high
  output accel_pkg::rx_beat_t  o_rx,
  output accel_pkg::spi_pins_t o_spi
);

  accel_pkg::cs_state_e  r_state;
  accel_pkg::frame_cnt_t r_remaining;  // Bytes still due after the current one
  accel_pkg::gap_cnt_t   r_gap_cnt;
  logic                  r_cs_n;
  logic                  w_eng_ready;
  logic                  w_sclk;
  logic                  w_mosi;

  spi_byte_engine u_engine
  (
    .i_Clk   (i_Clk),
    .i_Rst_L (i_Rst_L),
    .i_tx    (i_tx),         // Strobe and byte go straight through
    .i_miso  (i_miso),
    .o_ready (w_eng_ready),
    .o_rx    (o_rx),
    .o_sclk  (w_sclk),
    .o_mosi  (w_mosi)
  );

  //////////////////////////////
  // Chip select FSM
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state     <= accel_pkg::CS_IDLE;
      r_cs_n      <= 1'b1;
      r_remaining <= '0;
      r_gap_cnt   <= '0;
    end
    else
    begin
      case (r_state)
        accel_pkg::CS_IDLE:
        begin
          if (r_cs_n && i_tx.dv)  // First byte carries the length
          begin
            r_remaining <= i_tx.count - 1'b1;
            r_cs_n      <= 1'b0;
            r_state     <= accel_pkg::CS_TRANSFER;
          end
        end
        accel_pkg::CS_TRANSFER:
        begin
          if (w_eng_ready)
          begin
            if (r_remaining != '0)
            begin
              if (i_tx.dv)
              begin
                r_remaining <= r_remaining - 1'b1;
              end
            end
            else
            begin
              r_cs_n    <= 1'b1;  // Last byte finished
              r_gap_cnt <= accel_pkg::gap_cnt_t'(accel_pkg::CS_INACTIVE_CLKS);
              r_state   <= accel_pkg::CS_GAP;
            end
          end
        end
        accel_pkg::CS_GAP:
        begin
          if (r_gap_cnt != '0)
          begin
            r_gap_cnt <= r_gap_cnt - 1'b1;
          end
          else
          begin
            r_state <= accel_pkg::CS_IDLE;
          end
        end
        default:
        begin
          r_cs_n  <= 1'b1;
          r_state <= accel_pkg::CS_IDLE;
        end
      endcase
    end
  end

  // Ready between bytes of a frame, or when idle, and dropped with the strobe
  assign o_tx_ready = w_eng_ready & ~i_tx.dv &
                      ((r_state == accel_pkg::CS_IDLE) |
                       ((r_state == accel_pkg::CS_TRANSFER) & (r_remaining != '0)));

  assign o_spi = '{sclk: w_sclk, mosi: w_mosi, cs_n: r_cs_n};

endmodule

`default_nettype wire

//--- src/spi_byte_engine.sv
// Mode 0 SPI master bit engine, one byte out on MOSI and one in from MISO per tx strobe
`timescale 1ns/1ns
`default_nettype none

module spi_byte_engine
(
  input  wire                 i_Clk,
  input  wire                 i_Rst_L,
  input  wire accel_pkg::tx_req_t i_tx,    // Strobe and byte from the framer
  input  wire                 i_miso,
  output logic                o_ready,     // High while no byte is in flight
  output accel_pkg::rx_beat_t o_rx,
  output logic                o_sclk,
  output logic                o_mosi
);

  logic                 r_tx_dv;     // Strobe delayed one clock
  logic [7:0]           r_tx_byte;   // Local copy, upstream may change data
  accel_pkg::half_cnt_t r_half_cnt;
  accel_pkg::edge_cnt_t r_edges;
  logic                 r_sclk;      // Internal clock, output copy lags one cycle
  logic                 r_lead;      // Rising edge marker
  logic                 r_trail;     // Falling edge marker
  logic [2:0]           r_tx_bit;
  logic [2:0]           r_rx_bit;
  logic                 r_rx_dv;
  logic [7:0]           r_rx_byte;

  assign o_rx = '{dv: r_rx_dv, data: r_rx_byte};

  //////////////////////////////
  // SCLK generation
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_ready    <= 1'b0;
      r_edges    <= '0;
      r_half_cnt <= '0;
      r_sclk     <= 1'b0;  // Mode 0 idles low
      r_lead     <= 1'b0;
      r_trail    <= 1'b0;
    end
    else
    begin
      r_lead  <= 1'b0;
      r_trail <= 1'b0;
      if (i_tx.dv)
      begin
        o_ready <= 1'b0;
        r_edges <= accel_pkg::edge_cnt_t'(accel_pkg::EDGES_PER_BYTE);
      end
      else if (r_edges != '0)
      begin
        if (r_half_cnt == accel_pkg::half_cnt_t'(2 * accel_pkg::CLKS_PER_HALF_BIT - 1))
        begin
          r_edges    <= r_edges - 1'b1;
          r_half_cnt <= '0;     // End of one bit period
          r_sclk     <= 1'b0;
          r_trail    <= 1'b1;
        end
        else if (r_half_cnt == accel_pkg::half_cnt_t'(accel_pkg::CLKS_PER_HALF_BIT - 1))
        begin
          r_edges    <= r_edges - 1'b1;
          r_half_cnt <= r_half_cnt + 1'b1;
          r_sclk     <= 1'b1;
          r_lead     <= 1'b1;
        end
        else
        begin
          r_half_cnt <= r_half_cnt + 1'b1;
        end
      end
      else
      begin
        o_ready <= 1'b1;  // All edges done
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (i_tx.dv)
    begin
      r_tx_byte <= i_tx.data;
    end
  end

  // MOSI, MSB first, next bit after each falling edge
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_tx_dv  <= 1'b0;
      o_mosi   <= 1'b0;
      r_tx_bit <= 3'd7;
    end
    else
    begin
      r_tx_dv <= i_tx.dv;
      if (o_ready)
      begin
        r_tx_bit <= 3'd7;
      end
      else if (r_tx_dv)
      begin
        o_mosi   <= r_tx_byte[7];  // First bit well ahead of the first rise
        r_tx_bit <= 3'd6;
      end
      else if (r_trail)
      begin
        o_mosi   <= r_tx_byte[r_tx_bit];
        r_tx_bit <= r_tx_bit - 1'b1;
      end
    end
  end

  // MISO bit counter and byte strobe
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_rx_dv  <= 1'b0;
      r_rx_bit <= 3'd7;
    end
    else
    begin
      r_rx_dv <= 1'b0;
      if (o_ready)
      begin
        r_rx_bit <= 3'd7;
      end
      else if (r_lead)
      begin
        r_rx_bit <= r_rx_bit - 1'b1;
        r_rx_dv  <= (r_rx_bit == 3'd0);  // Eighth sample
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (r_lead && !o_ready)
    begin
      r_rx_byte[r_rx_bit] <= i_miso;  // Sampled as SCLK rises on the pin
    end
  end

  // Output clock lags one cycle so MOSI settles first
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_sclk <= 1'b0;
    end
    else
    begin
      o_sclk <= r_sclk;
    end
  end

endmodule

`default_nettype wire

//--- src/accel_pkg.sv
// Shared constants, sensor codes and bus types for the accelerometer ID reader, compile first
`default_nettype none

package accel_pkg;

  //////////////////////////////
  // Timing and frame sizes
  //////////////////////////////
  localparam int CLKS_PER_HALF_BIT   = 4;   // System clocks per SCLK half period
  localparam int EDGES_PER_BYTE      = 16;  // Rising plus falling SCLK edges in one byte
  localparam int MAX_BYTES_PER_FRAME = 3;   // Longest frame under one CS low
  localparam int CS_INACTIVE_CLKS    = 2;   // CS high time before the next frame
  localparam int FRAME_COUNT_W       = 2;

  // Counter widths derived from the timing above
  localparam int HALF_CNT_W = $clog2(2 * CLKS_PER_HALF_BIT);
  localparam int EDGE_CNT_W = $clog2(EDGES_PER_BYTE + 1);
  localparam int GAP_CNT_W  = $clog2(CS_INACTIVE_CLKS + 1);

  typedef logic [HALF_CNT_W-1:0]    half_cnt_t;   // Position inside one SCLK period
  typedef logic [EDGE_CNT_W-1:0]    edge_cnt_t;   // SCLK edges left in the byte
  typedef logic [GAP_CNT_W-1:0]     gap_cnt_t;
  typedef logic [FRAME_COUNT_W-1:0] frame_cnt_t;  // Bytes per frame

  //////////////////////////////
  // Sensor registers and data
  //////////////////////////////
  localparam logic [7:0] REG_POWER_CTL = 8'h2D;
  localparam logic [7:0] REG_DEVID     = 8'h08;
  localparam logic [7:0] WAKE_VALUE    = 8'h0A;  // Measurement mode
  localparam logic [7:0] DUMMY_BYTE    = 8'h94;  // Filler while the ID is clocked in

  typedef enum logic [7:0] {
    CMD_WRITE = 8'h0A,
    CMD_READ  = 8'h0B
  } spi_cmd_e;

  //////////////////////////////
  // Bus bundles
  //////////////////////////////
  typedef struct packed {
    logic       dv;     // One-cycle strobe
    logic [7:0] data;
    frame_cnt_t count;  // Frame length, looked at on the first byte only
  } tx_req_t;

  typedef struct packed {
    logic       dv;     // Pulses after the eighth MISO sample
    logic [7:0] data;
  } rx_beat_t;

  typedef struct packed {
    logic sclk;
    logic mosi;
    logic cs_n;
  } spi_pins_t;

  typedef enum logic [1:0] {CS_IDLE, CS_TRANSFER, CS_GAP} cs_state_e;

  // Send, drop-strobe and wait-ready for every byte of both frames
  typedef enum logic [4:0] {
    SEQ_IDLE,
    SEQ_WAKE_CMD_SEND, SEQ_WAKE_CMD_DROP, SEQ_WAKE_CMD_WAIT,
    SEQ_WAKE_REG_SEND, SEQ_WAKE_REG_DROP, SEQ_WAKE_REG_WAIT,
    SEQ_WAKE_VAL_SEND, SEQ_WAKE_VAL_DROP, SEQ_WAKE_VAL_WAIT,
    SEQ_RD_CMD_SEND,   SEQ_RD_CMD_DROP,   SEQ_RD_CMD_WAIT,
    SEQ_RD_REG_SEND,   SEQ_RD_REG_DROP,   SEQ_RD_REG_WAIT,
    SEQ_RD_DUMMY_SEND, SEQ_RD_DUMMY_DROP, SEQ_RD_DUMMY_WAIT
  } seq_state_e;

endpackage

`default_nettype wire
